// File: bench/lcd_clk_gen.sv
`timescale 1ns/1ps

module lcd_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;   // 10 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

// File: bench/lcd_props.sv
`timescale 1ns/1ps

module lcd_props (
	input logic                clk,
	input logic                rst_n,
	input lcd_pkg::seq_state_e state,
	input logic                e,
	input lcd_pkg::lcd_word_t  pin_word,
	input logic                bvalid,
	input logic                bready,
	input logic                rvalid,
	input logic                rready
);
	import lcd_pkg::*;

	// no enable pulse during reset or the power-up wait
	e_quiet_before_init: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_OFF || state == ST_POWERUP) |-> !e)
		else $error("enable high before the init sequence");

	pins_stable_while_e: assert property (@(posedge clk) disable iff (!rst_n)
		(e && $past(e)) |-> $stable(pin_word))
		else $error("rs, rw or data changed while enable high");

	bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		(bvalid && !bready) |=> bvalid)
		else $error("bvalid dropped before bready");

	rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		(rvalid && !rready) |=> rvalid)
		else $error("rvalid dropped before rready");

endmodule

// File: bench/lcd_tb.sv
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_tb;
	import lcd_pkg::*;

	localparam int U = `LCD_UNIT;
	localparam int N_CMD = 28;   // single words plus the burst
	localparam longint WATCHDOG_NS = longint'(940 * U + 50 * U * N_CMD) * 10 + 60000;
	localparam int MAX_POLL = 1000;
	localparam int DRAIN_CYCLES = 60 * U * (`LCD_FIFO_DEPTH + 4);
	localparam logic [3:0] ADDR_CTRL = 4'h0;
	localparam logic [3:0] ADDR_CMD = 4'h4;
	localparam logic [3:0] ADDR_STATUS = 4'h8;
	localparam logic [3:0] ADDR_NONE = 4'hC;
	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	logic        clk;
	logic        rst_n;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        e;
	logic        rs;
	logic        rw;
	logic [7:0]  lcd_data;

	lcd_word_t exp_q[$];          // words expected on the pins in order
	int        occ = 0;           // model queue occupancy
	bit        cmd_phase = 1'b0;
	int        cap_count = 0;
	int        n_checks = 0;
	int        n_errors = 0;
	logic      e_seen = 1'b0;     // enable at the previous falling clock edge

	lcd_clk_gen lcd_clk_gen_inst (
		.clk   (clk),
		.rst_n (rst_n)
	);

	lcd_top lcd_top_inst (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data)
	);

	bind lcd_seq lcd_props seq_props (
		.clk(clk), .rst_n(rst_n), .state(state), .e(e), .pin_word({rs, rw, lcd_data}),
		.bvalid(1'b0), .bready(1'b0), .rvalid(1'b0), .rready(1'b0)
	);

	bind lcd_axil_regs lcd_props axi_props (
		.clk(clk), .rst_n(rst_n), .state(lcd_pkg::ST_READY), .e(1'b0), .pin_word('0),
		.bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready)
	);

	task automatic report_error(input string msg);
		$display("ERROR: %s", msg);
		n_errors++;
	endtask

	task automatic check_word(input string name, input lcd_word_t got, input lcd_word_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			n_errors++;
		end
	endtask

	task automatic check_status(input string name, input lcd_status_t got,
			input lcd_status_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			n_errors++;
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			n_errors++;
		end
	endtask

	task automatic check_data(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			n_errors++;
		end
	endtask

	task automatic end_test(input string name, input int err0);
		if (n_errors == err0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, n_errors - err0);
	endtask

	// init command from the panel instruction set
	function automatic lcd_word_t init_cmd(input lcd_cfg_t c, input int idx);
		lcd_word_t w;
		w = '0;
		case (idx)
			0: w.data = 8'h30 | {4'd0, c.lines, c.font, 2'd0};
			1: w.data = 8'h08 | {5'd0, c.disp_on, c.cursor, c.blink};
			2: w.data = 8'h01;
			default: w.data = 8'h04 | {6'd0, c.inc_dec, c.shift};
		endcase
		return w;
	endfunction

	// starts and ends 1 ns after a rising edge
	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] resp, output int occ_at_fire);
		int unsigned dly;
		bit          hs;
		dly = $urandom_range(3, 0);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clk);
			hs = awready;
			if (wready !== awready)
				report_error("awready and wready did not pulse together");
			@(posedge clk);
			#1;
		end
		occ_at_fire = occ;
		awvalid = 1'b0;
		wvalid = 1'b0;
		repeat (dly) begin
			@(posedge clk);
			#1;
		end
		bready = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clk);
			hs = bvalid;
			resp = bresp;
			@(posedge clk);
			#1;
		end
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int unsigned dly;
		bit          hs;
		dly = $urandom_range(3, 0);
		araddr = addr;
		arvalid = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clk);
			hs = arready;
			@(posedge clk);
			#1;
		end
		arvalid = 1'b0;
		repeat (dly) begin
			@(posedge clk);
			#1;
		end
		rready = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clk);
			hs = rvalid;
			data = rdata;
			resp = rresp;
			@(posedge clk);
			#1;
		end
		rready = 1'b0;
	endtask

	// accepted only after init and below depth
	task automatic cmd_write(input lcd_word_t w);
		logic [1:0] resp;
		int         occ_seen;
		bit         accept;
		axi_write(ADDR_CMD, {22'd0, w}, resp, occ_seen);
		accept = cmd_phase && (occ_seen < `LCD_FIFO_DEPTH);
		check_resp("bresp", resp, accept ? OKAY : SLVERR);
		if (accept) begin
			occ++;
			exp_q.push_back(w);
		end
	endtask

	task automatic poll_status(input bit want_init, output lcd_status_t st);
		logic [31:0] rd;
		logic [1:0]  resp;
		int          n;
		bit          done;
		n = 0;
		done = 1'b0;
		while (!done && n < MAX_POLL) begin
			axi_read(ADDR_STATUS, rd, resp);
			check_resp("rresp", resp, OKAY);
			st = lcd_status_t'(rd[8:0]);
			done = want_init ? st.init_done : !st.seq_busy;
			n++;
		end
		if (!done)
			report_error(want_init ? "init_done never rose" : "sequencer stayed busy");
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_CYCLES) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (exp_q.size() != 0)
			report_error("queued words did not reach the panel in time");
	endtask

	// a queued word leaves the FIFO as its slot opens
	always @(posedge e) begin
		if (rst_n === 1'b1 && cmd_phase)
			occ--;
	end

	// pins sampled mid-cycle, the word counts once the enable has fallen
	always @(negedge clk) begin
		if (rst_n === 1'b1 && e_seen === 1'b1 && e === 1'b0) begin
			cap_count++;
			if (exp_q.size() == 0)
				report_error("enable pulse with no word expected");
			else
				check_word("panel word", {rs, rw, lcd_data}, exp_q.pop_front());
		end
		e_seen = e;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		lcd_cfg_t    cfg;
		lcd_status_t st;
		lcd_status_t exp_st;
		lcd_word_t   w;
		logic [1:0]  resp;
		logic [31:0] rd;
		logic [31:0] v;
		int          occ_seen;
		int          err0;
		void'($urandom(32'h4451));
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		@(posedge rst_n);
		@(posedge clk);
		#1;

		err0 = n_errors;
		cmd_write(lcd_word_t'(10'h155));   // dropped since init is not started
		repeat (20) @(posedge clk);
		#1;
		if (cap_count != 0)
			report_error("enable pulse seen before init was started");
		end_test("cmd before start", err0);

		err0 = n_errors;
		cfg = lcd_cfg_t'(7'($urandom()));
		for (int i = 0; i < 4; i++)
			exp_q.push_back(init_cmd(cfg, i));
		axi_write(ADDR_CTRL, {23'd0, 1'b1, 1'b0, cfg}, resp, occ_seen);
		check_resp("bresp", resp, OKAY);
		poll_status(1'b1, st);
		if (exp_q.size() != 0)
			report_error("init commands missing on the panel pins");
		exp_st = '{init_done: 1'b1, seq_busy: 1'b0, fifo_full: 1'b0, fifo_empty: 1'b1,
			fifo_level: '0};
		check_status("status", st, exp_st);
		cmd_phase = 1'b1;
		end_test("init sequence", err0);

		err0 = n_errors;
		for (int i = 0; i < 8; i++) begin
			w = lcd_word_t'(10'($urandom()));
			cmd_write(w);
			wait_drain();
		end
		end_test("single commands", err0);

		err0 = n_errors;
		for (int i = 0; i < 20; i++) begin
			w = lcd_word_t'(10'($urandom()));
			cmd_write(w);
		end
		wait_drain();
		end_test("burst of 20", err0);

		err0 = n_errors;
		poll_status(1'b0, st);
		check_status("status", st, exp_st);
		end_test("status after drain", err0);

		err0 = n_errors;
		axi_write(ADDR_NONE, 32'h0000_00ff, resp, occ_seen);
		check_resp("bresp", resp, SLVERR);
		axi_write(ADDR_STATUS, 32'h0000_0000, resp, occ_seen);
		check_resp("bresp", resp, SLVERR);
		axi_read(ADDR_NONE, rd, resp);
		check_resp("rresp", resp, SLVERR);
		check_data("rdata", rd, 32'h0);
		v = $urandom();
		axi_write(ADDR_CTRL, v, resp, occ_seen);
		check_resp("bresp", resp, OKAY);
		axi_read(ADDR_CTRL, rd, resp);
		check_resp("rresp", resp, OKAY);
		check_data("rdata", rd, v & 32'h0000_017f);   // cfg in 6:0 and start in 8
		end_test("address map", err0);

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module lcd_tb -f tb.f -o lcd_sim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/lcd_sim > sim.log 2>&1
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// File: src/lcd_axil_regs.sv
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_axil_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [3:0]              awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [31:0]             wdata,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [3:0]              araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [31:0]             rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	output lcd_pkg::lcd_cfg_t       cfg,
	output logic                    start,
	output logic                    push,
	output lcd_pkg::lcd_word_t      push_word,
	input  logic                    fifo_full,
	input  logic                    fifo_empty,
	input  logic [`LCD_LEVEL_W-1:0] fifo_level,
	input  logic                    init_done,
	input  logic                    seq_busy
);
	import lcd_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	lcd_status_t status;
	logic        wr_rdy;     // shared aw/w ready pulse
	logic        wr_fire;
	logic        rd_fire;
	logic        start_bit;
	logic [31:0] rd_data;
	logic        rd_err;

	function automatic logic addr_hit(input logic [3:0] addr);
		return addr[3:2] inside {REG_CTRL, REG_CMD, REG_STATUS};
	endfunction

	assign awready = wr_rdy;
	assign wready  = wr_rdy;
	assign wr_fire = wr_rdy && awvalid && wvalid;
	assign rd_fire = arready && arvalid;

	assign status = '{
		init_done:  init_done,
		seq_busy:   seq_busy,
		fifo_full:  fifo_full,
		fifo_empty: fifo_empty,
		fifo_level: fifo_level
	};

	// write channel, one outstanding
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_rdy    <= 1'b0;
			bvalid    <= 1'b0;
			bresp     <= RESP_OKAY;
			cfg       <= '0;
			start_bit <= 1'b0;
			start     <= 1'b0;
			push      <= 1'b0;
		end else begin
			wr_rdy <= awvalid && wvalid && !bvalid && !wr_rdy;
			start  <= 1'b0;
			push   <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_fire) begin
				bvalid <= 1'b1;
				bresp  <= RESP_OKAY;
				if (!addr_hit(awaddr)) begin
					bresp <= RESP_SLVERR;
				end else begin
					case (reg_addr_e'(awaddr[3:2]))
						REG_CTRL: begin
							cfg       <= lcd_cfg_t'(wdata[6:0]);
							start_bit <= wdata[8];
							start     <= wdata[8] && !init_done;   // only before init
						end
						REG_CMD: begin
							if (fifo_full || !init_done)
								bresp <= RESP_SLVERR;   // word dropped
							else
								push <= 1'b1;
						end
						default: bresp <= RESP_SLVERR;   // status is read only
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire)
			push_word <= lcd_word_t'(wdata[9:0]);
	end

	always_comb begin
		rd_data = '0;
		rd_err  = 1'b0;
		if (!addr_hit(araddr)) begin
			rd_err = 1'b1;
		end else begin
			case (reg_addr_e'(araddr[3:2]))
				REG_CTRL:   rd_data = {23'd0, start_bit, 1'b0, cfg};
				REG_STATUS: rd_data = 32'(status);
				default:    rd_err = 1'b1;   // command register is write only
			endcase
		end
	end

	// read channel, one outstanding
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rresp   <= RESP_OKAY;
		end else begin
			arready <= arvalid && !rvalid && !arready;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rd_fire) begin
				rvalid <= 1'b1;
				rresp  <= rd_err ? RESP_SLVERR : RESP_OKAY;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire)
			rdata <= rd_data;
	end

endmodule

// File: src/lcd_cmd_fifo.sv
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_cmd_fifo (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    push,
	input  lcd_pkg::lcd_word_t      push_word,
	input  logic                    pop,
	output lcd_pkg::lcd_word_t      head,
	output logic                    full,
	output logic                    empty,
	output logic [`LCD_LEVEL_W-1:0] level
);
	import lcd_pkg::*;

	localparam int DEPTH = `LCD_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	lcd_word_t               mem [DEPTH];
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic [`LCD_LEVEL_W-1:0] count;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign head  = mem[rd_ptr];   // show-ahead
	assign full  = (count == `LCD_LEVEL_W'(DEPTH));
	assign empty = (count == '0);
	assign level = count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_word;
	end

endmodule

// File: src/lcd_macros.svh
`ifndef LCD_MACROS_SVH
`define LCD_MACROS_SVH

// clock cycles per delay unit
`define LCD_UNIT 2
`define LCD_FIFO_DEPTH 16
// occupancy width, holds 0 to LCD_FIFO_DEPTH
`define LCD_LEVEL_W 5

// panel delays in units
`define LCD_T_POWERUP 500
`define LCD_T_CMD 50
`define LCD_T_EHI_START 1
`define LCD_T_EHI_END 14
`define LCD_T_EHI_INIT 10
`define LCD_T_CLEAR 200
`define LCD_T_ENTRY 100

`endif

// File: src/lcd_pkg.sv
`include "lcd_macros.svh"

package lcd_pkg;

	// one panel bus word, same bit order as the raw 10-bit bus
	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_word_t;

	typedef struct packed {
		logic lines;   // bit 6
		logic font;
		logic disp_on;
		logic cursor;
		logic blink;
		logic inc_dec;
		logic shift;   // bit 0
	} lcd_cfg_t;

	typedef struct packed {
		logic                    init_done;
		logic                    seq_busy;
		logic                    fifo_full;
		logic                    fifo_empty;
		logic [`LCD_LEVEL_W-1:0] fifo_level;
	} lcd_status_t;

	// five states need three bits
	typedef enum logic [2:0] {
		ST_OFF,
		ST_POWERUP,
		ST_INIT,
		ST_READY,
		ST_PULSE
	} seq_state_e;

	typedef enum logic [1:0] {
		REG_CTRL   = 2'd0,
		REG_CMD    = 2'd1,
		REG_STATUS = 2'd2
	} reg_addr_e;

endpackage

// File: src/lcd_seq.sv
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_seq (
	input  logic               clk,
	input  logic               rst_n,
	input  lcd_pkg::lcd_cfg_t  cfg,
	input  logic               start,
	input  lcd_pkg::lcd_word_t head,
	input  logic               empty,
	output logic               pop,
	output logic               init_done,
	output logic               seq_busy,
	output logic               e,
	output logic               rs,
	output logic               rw,
	output logic [7:0]         lcd_data
);
	import lcd_pkg::*;

	// power-up is the longest count
	localparam int SLOT_W = $clog2(`LCD_T_POWERUP + 1);
	localparam int UNIT_W = $clog2(`LCD_UNIT + 1);
	localparam int INIT_SLOT = `LCD_T_CMD + `LCD_T_EHI_INIT;

	// init step boundaries on the running slot count
	localparam logic [SLOT_W-1:0] S_DC = SLOT_W'(INIT_SLOT);
	localparam logic [SLOT_W-1:0] S_CLR = SLOT_W'(2 * INIT_SLOT);
	localparam logic [SLOT_W-1:0] S_ENT = S_CLR + SLOT_W'(`LCD_T_CLEAR + `LCD_T_EHI_INIT);
	localparam logic [SLOT_W-1:0] S_INIT_LAST =
		S_ENT + SLOT_W'(`LCD_T_ENTRY + `LCD_T_EHI_INIT - 1);
	localparam logic [SLOT_W-1:0] S_PWR_LAST = SLOT_W'(`LCD_T_POWERUP - 1);
	localparam logic [SLOT_W-1:0] S_CMD_LAST = SLOT_W'(`LCD_T_CMD - 1);
	localparam logic [SLOT_W-1:0] S_EHI_ON = SLOT_W'(`LCD_T_EHI_START);
	localparam logic [SLOT_W-1:0] S_EHI_OFF = SLOT_W'(`LCD_T_EHI_END);
	localparam logic [SLOT_W-1:0] S_EHI_INIT = SLOT_W'(`LCD_T_EHI_INIT);
	localparam logic [UNIT_W-1:0] U_LAST = UNIT_W'(`LCD_UNIT - 1);

	seq_state_e        state;
	seq_state_e        state_nxt;
	logic [UNIT_W-1:0] unit_cnt;
	logic [UNIT_W-1:0] unit_nxt;
	logic [SLOT_W-1:0] slot_cnt;
	logic [SLOT_W-1:0] slot_nxt;
	logic [SLOT_W-1:0] init_ofs;   // offset inside the current init slot
	lcd_word_t         init_word;
	lcd_word_t         pin_word;
	logic              tick;
	logic              take;
	logic              timed;
	logic              e_nxt;

	assign tick     = (unit_cnt == U_LAST);
	assign timed    = (state == ST_POWERUP) || (state == ST_INIT) || (state == ST_PULSE);
	assign seq_busy = timed;

	always_comb begin
		state_nxt = state;
		slot_nxt  = slot_cnt;
		take      = 1'b0;
		case (state)
			ST_OFF: begin
				if (start)
					state_nxt = ST_POWERUP;
			end
			ST_POWERUP: begin
				if (tick && slot_cnt == S_PWR_LAST)
					state_nxt = ST_INIT;
				else if (tick)
					slot_nxt = slot_cnt + 1'b1;
			end
			ST_INIT: begin
				if (tick && slot_cnt == S_INIT_LAST)
					state_nxt = ST_READY;
				else if (tick)
					slot_nxt = slot_cnt + 1'b1;
			end
			ST_READY: begin
				if (!empty) begin
					state_nxt = ST_PULSE;
					take      = 1'b1;
				end
			end
			ST_PULSE: begin
				if (tick && slot_cnt == S_CMD_LAST)
					state_nxt = ST_READY;
				else if (tick)
					slot_nxt = slot_cnt + 1'b1;
			end
			default: state_nxt = ST_OFF;
		endcase
		// every state change opens a fresh slot
		if (state_nxt != state) begin
			slot_nxt = '0;
			unit_nxt = '0;
		end else if (timed) begin
			unit_nxt = tick ? '0 : unit_cnt + 1'b1;
		end else begin
			unit_nxt = '0;
		end
	end

	// init command picked from the slot count
	always_comb begin
		init_word.rs = 1'b0;
		init_word.rw = 1'b0;
		if (slot_nxt < S_DC) begin
			init_word.data = {4'b0011, cfg.lines, cfg.font, 2'b00};   // function set
			init_ofs       = slot_nxt;
		end else if (slot_nxt < S_CLR) begin
			init_word.data = {5'b00001, cfg.disp_on, cfg.cursor, cfg.blink};
			init_ofs       = slot_nxt - S_DC;
		end else if (slot_nxt < S_ENT) begin
			init_word.data = 8'h01;   // clear
			init_ofs       = slot_nxt - S_CLR;
		end else begin
			init_word.data = {6'b000001, cfg.inc_dec, cfg.shift};   // entry mode
			init_ofs       = slot_nxt - S_ENT;
		end
	end

	// pin values for the next cycle
	always_comb begin
		case (state_nxt)
			ST_INIT: begin
				pin_word = init_word;
				e_nxt    = (init_ofs < S_EHI_INIT);
			end
			ST_PULSE: begin
				pin_word = take ? head : lcd_word_t'({rs, rw, lcd_data});   // held over the slot
				e_nxt    = (slot_nxt >= S_EHI_ON) && (slot_nxt < S_EHI_OFF);
			end
			default: begin
				pin_word = '0;
				e_nxt    = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_OFF;
			unit_cnt  <= '0;
			slot_cnt  <= '0;
			pop       <= 1'b0;
			init_done <= 1'b0;
			e         <= 1'b0;
			rs        <= 1'b0;
			rw        <= 1'b0;
			lcd_data  <= '0;
		end else begin
			state    <= state_nxt;
			unit_cnt <= unit_nxt;
			slot_cnt <= slot_nxt;
			pop      <= take;   // head already latched into the pins
			if (state == ST_INIT && state_nxt == ST_READY)
				init_done <= 1'b1;
			e                   <= e_nxt;
			{rs, rw, lcd_data} <= pin_word;
		end
	end

endmodule

// File: src/lcd_top.sv
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [3:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [3:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	output logic        e,
	output logic        rs,
	output logic        rw,
	output logic [7:0]  lcd_data
);
	import lcd_pkg::*;

	lcd_cfg_t                cfg;
	lcd_word_t               push_word;
	lcd_word_t               head;
	logic                    start;
	logic                    push;
	logic                    pop;
	logic                    fifo_full;
	logic                    fifo_empty;
	logic [`LCD_LEVEL_W-1:0] fifo_level;
	logic                    init_done;
	logic                    seq_busy;

	lcd_axil_regs lcd_axil_regs_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.cfg        (cfg),
		.start      (start),
		.push       (push),
		.push_word  (push_word),
		.fifo_full  (fifo_full),
		.fifo_empty (fifo_empty),
		.fifo_level (fifo_level),
		.init_done  (init_done),
		.seq_busy   (seq_busy)
	);

	lcd_cmd_fifo lcd_cmd_fifo_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (push),
		.push_word (push_word),
		.pop       (pop),
		.head      (head),
		.full      (fifo_full),
		.empty     (fifo_empty),
		.level     (fifo_level)
	);

	lcd_seq lcd_seq_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.start     (start),
		.head      (head),
		.empty     (fifo_empty),
		.pop       (pop),
		.init_done (init_done),
		.seq_busy  (seq_busy),
		.e         (e),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data)
	);

endmodule

// File: tb.f
+incdir+src
src/lcd_pkg.sv
src/lcd_axil_regs.sv
src/lcd_cmd_fifo.sv
src/lcd_seq.sv
src/lcd_top.sv
bench/lcd_clk_gen.sv
bench/lcd_props.sv
bench/lcd_tb.sv
